//--- trellis_config.svh
//----------------------------------------------------------------------
// Build-time sizes for the trace-back back end
// TB_DEPTH is both the table depth and the bits per trace; keep it a
// power of two so the age counters wrap cleanly
// OUT_SPACING must not exceed the symbol strobe spacing
//----------------------------------------------------------------------

`ifndef TRELLIS_CONFIG_SVH
`define TRELLIS_CONFIG_SVH

// Trace-back depth in symbols, also bits per trace
`define TB_DEPTH 8

// Width of one path metric, unsigned, larger is better
`define METRIC_BITS 10

// Clocks between output bit strobes
`define OUT_SPACING 4

`endif

//--- trellisPkg.sv
//----------------------------------------------------------------------
// Shared types for the 20-state trellis trace-back
// Metric width comes from the config header
//----------------------------------------------------------------------

`default_nettype none

`include "trellis_config.svh"

package trellisPkg;

   //-------------------------------------------------------------------
   // Trellis size
   //-------------------------------------------------------------------
   localparam int NUM_STATES = 20;

   // State number 0..19
   typedef logic [4:0] stateIndex_t;

   // One survivor bit per state, bit i is state i
   typedef logic [NUM_STATES-1:0] survivorWord_t;

   //-------------------------------------------------------------------
   // Metrics
   //-------------------------------------------------------------------
   typedef logic [`METRIC_BITS-1:0] pathMetric_t;   // Unsigned, larger wins

   // Element i belongs to state i
   typedef pathMetric_t [NUM_STATES-1:0] pathMetricArray_t;

endpackage

`default_nettype wire

//--- bestStateFinder.sv
//----------------------------------------------------------------------
// Index of the largest path metric, registered on symEn
// Ties go to the lowest state; result held until the next strobe
//----------------------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module bestStateFinder (
   input  logic                         clk,
   input  logic                         reset,
   input  logic                         symEn,
   input  trellisPkg::pathMetricArray_t metrics,
   output trellisPkg::stateIndex_t      bestIndex
);

   import trellisPkg::*;

   // Tree is padded to a power of two, leaves live at LEAVES..2*LEAVES-1
   localparam int LEAVES = 32;

   pathMetric_t nodeMetric [1:2*LEAVES-1];
   stateIndex_t nodeIndex  [1:2*LEAVES-1];

   //-------------------------------------------------------------------
   // Comparison tree
   //-------------------------------------------------------------------
   always_comb begin
      // Real states
      for (int i = 0; i < NUM_STATES; i++) begin
         nodeMetric[LEAVES+i] = metrics[i];
         nodeIndex[LEAVES+i]  = stateIndex_t'(i);
      end

      // Padding leaves sit right of every real state and lose any tie
      for (int i = NUM_STATES; i < LEAVES; i++) begin
         nodeMetric[LEAVES+i] = '0;
         nodeIndex[LEAVES+i]  = stateIndex_t'(i);
      end

      // Left child always covers the lower indices
      for (int n = LEAVES-1; n >= 1; n--) begin
         if (nodeMetric[2*n+1] > nodeMetric[2*n]) begin
            nodeMetric[n] = nodeMetric[2*n+1];
            nodeIndex[n]  = nodeIndex[2*n+1];
         end else begin
            nodeMetric[n] = nodeMetric[2*n];   // Equal keeps the lower state
            nodeIndex[n]  = nodeIndex[2*n];
         end
      end
   end

   //-------------------------------------------------------------------
   // Result register
   //-------------------------------------------------------------------
   always_ff @(posedge clk) begin
      if (reset) begin
         bestIndex <= '0;
      end else if (symEn) begin
         bestIndex <= nodeIndex[1];   // Root of the tree
      end
   end

endmodule

`default_nettype wire

//--- survivorTable.sv
//----------------------------------------------------------------------
// Last TB_DEPTH survivor words, one shift register per state
// Age 0 is the newest symbol; the read port is combinational
//----------------------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

`include "trellis_config.svh"

module survivorTable (
   input  logic                          clk,
   input  logic                          reset,
   input  logic                          symEn,
   input  trellisPkg::survivorWord_t     sel,
   input  logic [$clog2(`TB_DEPTH)-1:0]  readAge,
   output trellisPkg::survivorWord_t     column
);

   import trellisPkg::*;

   // Bit a of stateSr[s] is the decision of state s, a symbols ago
   logic [`TB_DEPTH-1:0] stateSr [NUM_STATES];

   //-------------------------------------------------------------------
   // Shift in one column per symbol
   //-------------------------------------------------------------------
   always_ff @(posedge clk) begin
      if (reset) begin
         for (int s = 0; s < NUM_STATES; s++) begin
            stateSr[s] <= '0;
         end
      end else if (symEn) begin
         for (int s = 0; s < NUM_STATES; s++) begin
            stateSr[s] <= {stateSr[s][`TB_DEPTH-2:0], sel[s]};   // Oldest drops off
         end
      end
   end

   //-------------------------------------------------------------------
   // Read the whole column at one age
   //-------------------------------------------------------------------
   always_comb begin
      for (int s = 0; s < NUM_STATES; s++) begin
         column[s] = stateSr[s][readAge];
      end
   end

endmodule

`default_nettype wire

//--- traceBackEngine.sv
//----------------------------------------------------------------------
// Arms a trace on every TB_DEPTH-th symbol and walks the table back,
// one bit per clock starting at age 0
// Assumes no symbol strobe arrives while a trace is running
//----------------------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

`include "trellis_config.svh"

module traceBackEngine (
   input  logic                          clk,
   input  logic                          reset,
   input  logic                          symEn,
   input  trellisPkg::stateIndex_t       bestIndex,
   input  trellisPkg::survivorWord_t     column,
   output logic [$clog2(`TB_DEPTH)-1:0]  readAge,
   output logic                          pushEn,
   output logic                          pushBit,
   output logic                          traceDone
);

   import trellisPkg::*;

   localparam int AGE_BITS = $clog2(`TB_DEPTH);
   localparam logic [AGE_BITS-1:0] LAST_AGE = AGE_BITS'(`TB_DEPTH - 1);

   logic [AGE_BITS-1:0] symCount;   // Strobes since the last trace
   logic [AGE_BITS-1:0] step;       // Age being read
   logic                active;
   logic                arm;
   stateIndex_t         stateReg;
   stateIndex_t         curState;

   // Bit 0 moves +7, bit 1 moves +13, both modulo 20
   function automatic stateIndex_t nextState(input stateIndex_t s, input logic b);
      logic [5:0] sum;
      sum = {1'b0, s} + (b ? 6'd13 : 6'd7);
      if (sum >= 6'(NUM_STATES)) begin
         sum = sum - 6'(NUM_STATES);
      end
      return sum[4:0];
   endfunction

   //-------------------------------------------------------------------
   // Symbol counter
   //-------------------------------------------------------------------
   assign arm = symEn && (symCount == LAST_AGE);

   always_ff @(posedge clk) begin
      if (reset) begin
         symCount <= '0;
      end else if (symEn) begin
         if (arm) begin
            symCount <= '0;
         end else begin
            symCount <= symCount + 1'b1;
         end
      end
   end

   //-------------------------------------------------------------------
   // Step control
   //-------------------------------------------------------------------
   always_ff @(posedge clk) begin
      if (reset) begin
         active <= 1'b0;
         step   <= '0;
      end else if (arm) begin
         active <= 1'b1;   // Table and bestIndex update on this same edge
         step   <= '0;
      end else if (active) begin
         if (step == LAST_AGE) begin
            active <= 1'b0;
            step   <= '0;
         end else begin
            step <= step + 1'b1;
         end
      end
   end

   //-------------------------------------------------------------------
   // State walk
   //-------------------------------------------------------------------
   // First step starts from the max-metric state directly
   assign curState = (step == '0) ? bestIndex : stateReg;

   always_ff @(posedge clk) begin
      if (active) begin
         stateReg <= nextState(curState, pushBit);
      end
   end

   assign readAge   = step;
   assign pushEn    = active;
   assign pushBit   = column[curState];            // Survivor bit of the current state
   assign traceDone = active && (step == LAST_AGE);  // With the last push

endmodule

`default_nettype wire

//--- bitLifo.sv
//----------------------------------------------------------------------
// Bit stack, TB_DEPTH deep, played back newest first
// Pops start OUT_SPACING clocks after traceDone, then every OUT_SPACING
// Pushes and pops of one trace must not overlap the next trace
//----------------------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

`include "trellis_config.svh"

module bitLifo (
   input  logic clk,
   input  logic reset,
   input  logic pushEn,
   input  logic pushBit,
   input  logic traceDone,
   output logic decision,
   output logic decisionValid
);

   localparam int AW         = $clog2(`TB_DEPTH);
   localparam int PTR_BITS   = $clog2(`TB_DEPTH + 1);
   localparam int SPACE_BITS = $clog2(`OUT_SPACING) + 1;

   logic [`TB_DEPTH-1:0]  stack;
   logic [PTR_BITS-1:0]   ptr;       // Number of bits held
   logic [AW-1:0]         topIdx;
   logic                  popping;
   logic [SPACE_BITS-1:0] spaceCnt;  // Clocks left to the next pop

   assign topIdx = AW'(ptr - 1'b1);

   always_ff @(posedge clk) begin
      if (reset) begin
         stack    <= '0;
         ptr      <= '0;
         popping  <= 1'b0;
         spaceCnt <= '0;
      end else begin
         if (pushEn) begin
            stack[AW'(ptr)] <= pushBit;
            ptr             <= ptr + 1'b1;
         end

         if (traceDone) begin
            popping  <= 1'b1;
            spaceCnt <= SPACE_BITS'(`OUT_SPACING - 1);
         end else if (decisionValid) begin
            ptr      <= ptr - 1'b1;
            spaceCnt <= SPACE_BITS'(`OUT_SPACING - 1);
            if (ptr == PTR_BITS'(1)) begin
               popping <= 1'b0;   // Stack empty after this pop
            end
         end else if (popping) begin
            spaceCnt <= spaceCnt - 1'b1;
         end
      end
   end

   assign decisionValid = popping && (spaceCnt == '0);
   assign decision      = stack[topIdx];   // Last pushed comes out first

endmodule

`default_nettype wire

//--- trellisTraceback.sv
//----------------------------------------------------------------------
// Trace-back back end of the 20-state trellis demodulator
// Symbol strobes must be at least TB_DEPTH+2 clocks apart
// Arming strobe to first decisionValid is TB_DEPTH+OUT_SPACING clocks
//----------------------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

`include "trellis_config.svh"

module trellisTraceback (
   input  logic                         clk,
   input  logic                         reset,
   input  logic                         symEn,
   input  trellisPkg::survivorWord_t    sel,
   input  trellisPkg::pathMetricArray_t metrics,
   output logic                         decision,
   output logic                         decisionValid
);

   import trellisPkg::*;

   stateIndex_t                 bestIndex;
   survivorWord_t               column;
   logic [$clog2(`TB_DEPTH)-1:0] readAge;
   logic                        pushEn;
   logic                        pushBit;
   logic                        traceDone;

   //-------------------------------------------------------------------
   // Per-symbol front: start state and survivor history
   //-------------------------------------------------------------------
   bestStateFinder bestStateFinder_i (
      .clk       (clk),
      .reset     (reset),
      .symEn     (symEn),
      .metrics   (metrics),
      .bestIndex (bestIndex)
   );

   survivorTable survivorTable_i (
      .clk     (clk),
      .reset   (reset),
      .symEn   (symEn),
      .sel     (sel),
      .readAge (readAge),
      .column  (column)
   );

   //-------------------------------------------------------------------
   // Walk back and reverse into time order
   //-------------------------------------------------------------------
   traceBackEngine traceBackEngine_i (
      .clk       (clk),
      .reset     (reset),
      .symEn     (symEn),
      .bestIndex (bestIndex),
      .column    (column),
      .readAge   (readAge),
      .pushEn    (pushEn),
      .pushBit   (pushBit),
      .traceDone (traceDone)
   );

   bitLifo bitLifo_i (
      .clk           (clk),
      .reset         (reset),
      .pushEn        (pushEn),
      .pushBit       (pushBit),
      .traceDone     (traceDone),
      .decision      (decision),
      .decisionValid (decisionValid)
   );

endmodule

`default_nettype wire

//--- trellisTracebackTb.sv
//----------------------------------------------------------------------
// Testbench for trellisTraceback, stimulus from trellis_stimulus.txt
// Every TB_DEPTH S lines form one trace block, followed by its E line
// Symbol gaps never go below TB_DEPTH+2 clocks (no back-pressure)
//----------------------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

`include "trellis_config.svh"

module trellisTracebackTb;

   import trellisPkg::*;

   localparam int DEPTH   = `TB_DEPTH;
   localparam int SPACING = `OUT_SPACING;
   localparam int MIN_GAP = DEPTH + 2;
   localparam int LATENCY = DEPTH + SPACING;   // Arming strobe to first output
   localparam int TIMEOUT = 1000;              // Clocks

   logic             clk;
   logic             reset;
   logic             symEn;
   survivorWord_t    sel;
   pathMetricArray_t metrics;
   logic             decision;
   logic             decisionValid;

   // Symbols and expected bursts from the data file
   survivorWord_t    symSel [$];
   pathMetricArray_t symMetrics [$];
   logic [DEPTH-1:0] expBits [$];

   // Monitor records, emptied while reset is high
   int               edgeCount = 0;
   int               symEdges [$];
   int               outEdges [$];
   logic             outBits [$];

   trellisTraceback dut_i (
      .clk           (clk),
      .reset         (reset),
      .symEn         (symEn),
      .sel           (sel),
      .metrics       (metrics),
      .decision      (decision),
      .decisionValid (decisionValid)
   );

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   //-------------------------------------------------------------------
   // Error reporting
   //-------------------------------------------------------------------
   task automatic reportMismatch(input string testName, input logic [31:0] expected,
                                 input logic [31:0] actual);
      $display("** Error [%s] expected 'h%0h, actual 'h%0h", testName, expected, actual);
      $display("TESTS FAILED");
      $fatal(1, "Stopped at the first error");
   endtask

   task automatic reportFailure(input string msg);
      $display("Failure: %s", msg);
      $display("TESTS FAILED");
      $fatal(1, "Stopped at the first error");
   endtask

   //-------------------------------------------------------------------
   // Monitor
   //-------------------------------------------------------------------
   always @(posedge clk) begin
      edgeCount = edgeCount + 1;
      if (reset) begin
         assert (decisionValid !== 1'b1)
            else reportFailure("decisionValid was high during reset");
         symEdges.delete();
         outEdges.delete();
         outBits.delete();
      end else begin
         if (symEn) begin
            symEdges.push_back(edgeCount);
         end
         if (decisionValid) begin
            // No output before a full trace-back depth of symbols
            assert (symEdges.size() >= DEPTH)
               else reportFailure("decisionValid came before the first trace was armed");
            outEdges.push_back(edgeCount);
            outBits.push_back(decision);
         end
      end
   end

   //-------------------------------------------------------------------
   // Stimulus file and drivers
   //-------------------------------------------------------------------
   task automatic loadStimulus();
      int               fd;
      string            line;
      survivorWord_t    selVal;
      pathMetric_t      mv [NUM_STATES];
      pathMetricArray_t packedMetrics;
      logic [DEPTH-1:0] eb;
      fd = $fopen("trellis_stimulus.txt", "r");
      assert (fd != 0) else reportFailure("could not open trellis_stimulus.txt");
      while (!$feof(fd)) begin
         line = "";
         void'($fgets(line, fd));
         if ($sscanf(line, "S %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                     selVal, mv[0], mv[1], mv[2], mv[3], mv[4], mv[5], mv[6], mv[7], mv[8],
                     mv[9], mv[10], mv[11], mv[12], mv[13], mv[14], mv[15], mv[16], mv[17],
                     mv[18], mv[19]) == 21) begin
            for (int i = 0; i < NUM_STATES; i++) begin
               packedMetrics[i] = mv[i];
            end
            symSel.push_back(selVal);
            symMetrics.push_back(packedMetrics);
         end else if ($sscanf(line, "E %b", eb) == 1) begin
            expBits.push_back(eb);
         end
      end
      $fclose(fd);
      assert (expBits.size() > 0 && symSel.size() == expBits.size() * DEPTH)
         else reportFailure("stimulus file does not hold TB_DEPTH S lines per E line");
   endtask

   task automatic applyReset();
      reset <= 1'b1;
      symEn <= 1'b0;
      repeat (5) @(posedge clk);
      reset <= 1'b0;
      @(posedge clk);
   endtask

   // Called on a rising edge; gap is the clock count to the next strobe
   task automatic driveSymbol(input int idx, input int gap);
      symEn   <= 1'b1;
      sel     <= symSel[idx];
      metrics <= symMetrics[idx];
      @(posedge clk);
      symEn <= 1'b0;
      repeat (gap - 1) @(posedge clk);
   endtask

   //-------------------------------------------------------------------
   // Burst checks
   //-------------------------------------------------------------------
   task automatic waitForBits(input string testName, input int count);
      int waited;
      waited = 0;
      while (outBits.size() < count) begin
         @(posedge clk);
         waited++;
         assert (waited < TIMEOUT)
            else reportFailure({testName, ": timed out waiting for decisionValid strobes"});
      end
   endtask

   task automatic checkBurst(input string testName, input int b,
                             input logic [DEPTH-1:0] expected);
      int               first;
      int               arm;
      logic [DEPTH-1:0] got;
      first = b * DEPTH;
      arm   = symEdges[first + DEPTH - 1];   // Every TB_DEPTH-th symbol arms a trace
      assert (outEdges[first] - arm == LATENCY)
         else reportMismatch({testName, " latency"}, LATENCY, outEdges[first] - arm);
      for (int i = 1; i < DEPTH; i++) begin
         assert (outEdges[first+i] - outEdges[first+i-1] == SPACING)
            else reportMismatch({testName, " spacing"}, SPACING,
                                outEdges[first+i] - outEdges[first+i-1]);
      end
      for (int i = 0; i < DEPTH; i++) begin
         got[DEPTH-1-i] = outBits[first+i];   // Oldest symbol comes out first
      end
      assert (got == expected) else reportMismatch({testName, " bits"}, expected, got);
   endtask

   task automatic collectBursts(input string testName, input int firstExp, input int nBursts);
      waitForBits(testName, nBursts * DEPTH);
      repeat (LATENCY + DEPTH * SPACING) @(posedge clk);   // Room for stray strobes
      assert (outBits.size() == nBursts * DEPTH)
         else reportMismatch({testName, " strobe count"}, nBursts * DEPTH, outBits.size());
      for (int b = 0; b < nBursts; b++) begin
         checkBurst(testName, b, expBits[firstExp + b]);
      end
   endtask

   task automatic runPass(input string testName, input bit randomGaps);
      int gap;
      applyReset();
      for (int i = 0; i < symSel.size(); i++) begin
         gap = randomGaps ? MIN_GAP + int'($urandom_range(6, 0)) : MIN_GAP;
         driveSymbol(i, gap);
      end
      collectBursts(testName, 0, expBits.size());
   endtask

   // A partial block, then reset; the next full block must arm on its own
   task automatic runMidReset();
      int last;
      last = expBits.size() - 1;
      applyReset();
      for (int i = 0; i < 3; i++) begin
         driveSymbol(i, MIN_GAP);
      end
      applyReset();
      for (int j = 0; j < DEPTH; j++) begin
         driveSymbol(last * DEPTH + j, MIN_GAP + int'($urandom_range(6, 0)));
      end
      collectBursts("midReset", last, 1);
   endtask

   //-------------------------------------------------------------------
   // Main sequence
   //-------------------------------------------------------------------
   initial begin
      reset   = 1'b1;
      symEn   = 1'b0;
      sel     = '0;
      metrics = '0;
      void'($urandom(32'h060a_1bfd));
      loadStimulus();
      @(posedge clk);

      // Both spacings are held to the same expected bursts
      runPass("randomGap", 1'b1);
      runPass("minGap", 1'b0);

      runMidReset();

      $display("TESTS PASSED");
      $finish;
   end

endmodule

`default_nettype wire

//--- trellis_stimulus.txt
# S <sel hex, bit i = state i> <metrics hex, state 0 first ... state 19 last>
# E <expected output bits of the block above, first output bit first>
# Block 0: best state 5
S 3a5c1 100 0a3 1c7 05e 2b0 13d 08f 1f2 0c4 221 17a 06b 1e9 0d0 2a4 112 03c 19b 0f5 250
S 0f0f0 2e1 04d 130 1a8 099 3a2 0b7 16c 27f 01e 1d4 0e8 305 142 08a 2c9 11b 3b0 076 1f0
S c3a96 100 0a3 1c7 05e 2b0 13d 08f 1f2 0c4 221 17a 06b 1e9 0d0 2a4 112 03c 19b 0f5 250
S 5555a 2e1 04d 130 1a8 099 3a2 0b7 16c 27f 01e 1d4 0e8 305 142 08a 2c9 11b 3b0 076 1f0
S 81e24 100 0a3 1c7 05e 2b0 13d 08f 1f2 0c4 221 17a 06b 1e9 0d0 2a4 112 03c 19b 0f5 250
S 6b3d7 2e1 04d 130 1a8 099 3a2 0b7 16c 27f 01e 1d4 0e8 305 142 08a 2c9 11b 3b0 076 1f0
S f00c3 100 0a3 1c7 05e 2b0 13d 08f 1f2 0c4 221 17a 06b 1e9 0d0 2a4 112 03c 19b 0f5 250
S 2d4b8 100 0a3 1c7 05e 2b0 3f0 08f 1f2 0c4 221 17a 06b 1e9 0d0 2a4 112 03c 19b 0f5 250
E 01100011
# Block 1: all metrics equal, tie goes to state 0
S a5a5a 200 200 200 200 200 200 200 200 200 200 200 200 200 200 200 200 200 200 200 200
S 13579 200 200 200 200 200 200 200 200 200 200 200 200 200 200 200 200 200 200 200 200
S fedcb 200 200 200 200 200 200 200 200 200 200 200 200 200 200 200 200 200 200 200 200
S 0c0c0 200 200 200 200 200 200 200 200 200 200 200 200 200 200 200 200 200 200 200 200
S 7e817 200 200 200 200 200 200 200 200 200 200 200 200 200 200 200 200 200 200 200 200
S 92492 200 200 200 200 200 200 200 200 200 200 200 200 200 200 200 200 200 200 200 200
S 48d15 200 200 200 200 200 200 200 200 200 200 200 200 200 200 200 200 200 200 200 200
S e3c6f 200 200 200 200 200 200 200 200 200 200 200 200 200 200 200 200 200 200 200 200
E 01110001
# Block 2: best state 19
S 6d2e9 2e1 04d 130 1a8 099 3a2 0b7 16c 27f 01e 1d4 0e8 305 142 08a 2c9 11b 3b0 076 1f0
S b0471 100 0a3 1c7 05e 2b0 13d 08f 1f2 0c4 221 17a 06b 1e9 0d0 2a4 112 03c 19b 0f5 250
S 2f8c3 2e1 04d 130 1a8 099 3a2 0b7 16c 27f 01e 1d4 0e8 305 142 08a 2c9 11b 3b0 076 1f0
S d9a06 100 0a3 1c7 05e 2b0 13d 08f 1f2 0c4 221 17a 06b 1e9 0d0 2a4 112 03c 19b 0f5 250
S 4471b 2e1 04d 130 1a8 099 3a2 0b7 16c 27f 01e 1d4 0e8 305 142 08a 2c9 11b 3b0 076 1f0
S f8e2d 100 0a3 1c7 05e 2b0 13d 08f 1f2 0c4 221 17a 06b 1e9 0d0 2a4 112 03c 19b 0f5 250
S 1c3f4 2e1 04d 130 1a8 099 3a2 0b7 16c 27f 01e 1d4 0e8 305 142 08a 2c9 11b 3b0 076 1f0
S 8a6d5 100 0a3 1c7 05e 2b0 13d 08f 1f2 0c4 221 17a 06b 1e9 0d0 2a4 112 03c 19b 0f5 3ff
E 11110101
# Block 3: states 11 and 14 tie, state 11 wins
S 0f3c9 100 0a3 1c7 05e 2b0 13d 08f 1f2 0c4 221 17a 06b 1e9 0d0 2a4 112 03c 19b 0f5 250
S e1b26 2e1 04d 130 1a8 099 3a2 0b7 16c 27f 01e 1d4 0e8 305 142 08a 2c9 11b 3b0 076 1f0
S 5a0f4 100 0a3 1c7 05e 2b0 13d 08f 1f2 0c4 221 17a 06b 1e9 0d0 2a4 112 03c 19b 0f5 250
S 3c96a 2e1 04d 130 1a8 099 3a2 0b7 16c 27f 01e 1d4 0e8 305 142 08a 2c9 11b 3b0 076 1f0
S 9d071 100 0a3 1c7 05e 2b0 13d 08f 1f2 0c4 221 17a 06b 1e9 0d0 2a4 112 03c 19b 0f5 250
S 27e5c 2e1 04d 130 1a8 099 3a2 0b7 16c 27f 01e 1d4 0e8 305 142 08a 2c9 11b 3b0 076 1f0
S b4a83 100 0a3 1c7 05e 2b0 13d 08f 1f2 0c4 221 17a 06b 1e9 0d0 2a4 112 03c 19b 0f5 250
S 61f2e 100 0a3 1c7 05e 2b0 13d 08f 1f2 0c4 221 17a 380 1e9 0d0 380 112 03c 19b 0f5 250
E 01011101

//--- tb.f
+incdir+.
trellisPkg.sv
bestStateFinder.sv
survivorTable.sv
traceBackEngine.sv
bitLifo.sv
trellisTraceback.sv
trellisTracebackTb.sv

//--- run.sh
#!/bin/sh
# Compile and run the trace-back testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
   --top-module trellisTracebackTb \
   -f tb.f \
   -o trellisTracebackSim

# A failing check ends in $fatal, which gives a nonzero exit status
./obj_dir/trellisTracebackSim
